/* Makefile */
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_mem_subsystem
RTL_TOP   := mem_subsystem
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# RTL top alone, without the testbench
lint_rtl:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) +incdir+source \
		source/brisc_pkg.sv source/line_write_decode.sv source/cache_line_entry.sv \
		source/line_output_select.sv source/cache_top.sv source/line_fill_engine.sv \
		source/mem_subsystem.sv

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/brisc_config.svh */
`ifndef BRISC_CONFIG_SVH
`define BRISC_CONFIG_SVH

// Cache geometry
`define NUM_CACHE_LINES 8
`define ADDRESS_WIDTH 16
`define CACHE_LINE_WIDTH 128

// Datapath widths
`define XLEN 32
`define WORD_WIDTH 32
`define BYTE_WIDTH 8

// Backing store depth in words, covers the whole byte address space
`define MEM_WORDS 16384

// Cycles from grant to fill response
`define FILL_LATENCY 4

`endif

/* source/brisc_pkg.sv */
`default_nettype none

package brisc_pkg;

  // Access size seen by the pipeline and the store buffer
  typedef enum logic {
    B = 1'b0,
    W = 1'b1
  } data_size_e;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    WRITEBACK = 2'd1,
    WAIT      = 2'd2,
    RESPOND   = 2'd3
  } fill_state_e;

endpackage

`default_nettype wire

/* source/cache_line_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module cache_line_entry #(
  parameter int unsigned LINE_WIDTH = `CACHE_LINE_WIDTH,
  parameter int unsigned TAG_WIDTH  = 9
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fill_en,
  input  logic                       store_en,
  input  logic [TAG_WIDTH-1:0]       lookup_tag,
  input  logic [TAG_WIDTH-1:0]       fill_tag,
  input  logic [TAG_WIDTH-1:0]       store_tag,
  input  logic [LINE_WIDTH-1:0]      fill_data,
  input  logic [LINE_WIDTH-1:0]      store_line,
  input  logic [LINE_WIDTH/8-1:0]    store_mask,
  output logic [LINE_WIDTH-1:0]      line_data,
  output logic                       valid,
  output logic                       dirty,
  output logic [TAG_WIDTH-1:0]       tag,
  output logic                       lookup_hit
);
  localparam int unsigned BYTES_PER_LINE = LINE_WIDTH / `BYTE_WIDTH;

  logic store_hit;

  // Stores only land in a present line with matching tag
  assign store_hit  = store_en && valid && (store_tag == tag);
  assign lookup_hit = valid && (lookup_tag == tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      dirty <= 1'b0;
    end else if (fill_en) begin
      valid <= 1'b1;
      dirty <= 1'b0;
    end else if (store_hit) begin
      dirty <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      line_data <= fill_data;
      tag       <= fill_tag;
    end else if (store_hit) begin
      // Byte merge
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (store_mask[i]) begin
          line_data[i*`BYTE_WIDTH +: `BYTE_WIDTH] <= store_line[i*`BYTE_WIDTH +: `BYTE_WIDTH];
        end
      end
    end
  end

  // Fill engine and store buffer never target one line in the same cycle
  a_no_fill_store_overlap: assert property (
    @(posedge clk) disable iff (rst) !(fill_en && store_en)
  );

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module cache_top #(
  parameter int unsigned NUM_LINES  = `NUM_CACHE_LINES,
  parameter int unsigned ADDR_WIDTH = `ADDRESS_WIDTH,
  parameter int unsigned LINE_WIDTH = `CACHE_LINE_WIDTH
) (
  // Pipeline
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  logic                  is_load,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  brisc_pkg::data_size_e data_size,
  output logic                  miss,
  output logic [`XLEN-1:0]      read_data,

  // Fill engine
  input  logic                  arbiter_grant,
  output logic                  arbiter_req,
  output logic [ADDR_WIDTH-1:0] mem_req_addr,
  output logic [LINE_WIDTH-1:0] mem_req_data,
  output logic                  mem_req_write,
  input  logic                  mem_resp,
  input  logic [LINE_WIDTH-1:0] mem_resp_data,
  input  logic [ADDR_WIDTH-1:0] mem_resp_addr,

  // Store buffer
  input  logic [`XLEN-1:0]      stb_write_data,
  input  logic [ADDR_WIDTH-1:0] stb_write_addr,
  input  logic                  stb_read_valid,
  input  logic                  stb_write,
  input  brisc_pkg::data_size_e stb_write_size
);
  localparam int unsigned BYTE_SEL_WIDTH = $clog2(`WORD_WIDTH / `BYTE_WIDTH);
  localparam int unsigned WORD_SEL_WIDTH = $clog2(LINE_WIDTH / `WORD_WIDTH);
  localparam int unsigned LINE_OFFSET_WIDTH = BYTE_SEL_WIDTH + WORD_SEL_WIDTH;
  localparam int unsigned INDEX_WIDTH = $clog2(NUM_LINES);
  localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;

  logic [NUM_LINES-1:0]      fill_en;
  logic [NUM_LINES-1:0]      store_en;
  logic [LINE_WIDTH-1:0]     store_line;
  logic [LINE_WIDTH/8-1:0]   store_mask;

  logic [LINE_WIDTH-1:0]     entry_data [NUM_LINES];
  logic [TAG_WIDTH-1:0]      entry_tag [NUM_LINES];
  logic [NUM_LINES-1:0]      entry_valid;
  logic [NUM_LINES-1:0]      entry_dirty;
  logic [NUM_LINES-1:0]      entry_hit;

  logic [LINE_WIDTH-1:0]     line_data;
  logic                      cache_miss;
  logic                      cache_evict;
  logic [ADDR_WIDTH-1:0]     evict_addr;
  logic                      evict_sent;
  logic                      write_back;

  logic [WORD_SEL_WIDTH-1:0] word_offset;
  logic [BYTE_SEL_WIDTH-1:0] byte_offset;
  logic [`WORD_WIDTH-1:0]    read_word;
  logic [`BYTE_WIDTH-1:0]    read_byte;

  line_write_decode #(
    .NUM_LINES (NUM_LINES),
    .ADDR_WIDTH(ADDR_WIDTH),
    .LINE_WIDTH(LINE_WIDTH)
  ) u_decode (
    .mem_resp      (mem_resp),
    .mem_resp_addr (mem_resp_addr),
    .stb_write     (stb_write),
    .stb_write_addr(stb_write_addr),
    .stb_write_data(stb_write_data),
    .stb_write_size(stb_write_size),
    .fill_en       (fill_en),
    .store_en      (store_en),
    .store_line    (store_line),
    .store_mask    (store_mask)
  );

  for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
    cache_line_entry #(
      .LINE_WIDTH(LINE_WIDTH),
      .TAG_WIDTH (TAG_WIDTH)
    ) u_entry (
      .clk       (clk),
      .rst       (rst),
      .fill_en   (fill_en[i]),
      .store_en  (store_en[i]),
      .lookup_tag(addr[ADDR_WIDTH-1 -: TAG_WIDTH]),
      .fill_tag  (mem_resp_addr[ADDR_WIDTH-1 -: TAG_WIDTH]),
      .store_tag (stb_write_addr[ADDR_WIDTH-1 -: TAG_WIDTH]),
      .fill_data (mem_resp_data),
      .store_line(store_line),
      .store_mask(store_mask),
      .line_data (entry_data[i]),
      .valid     (entry_valid[i]),
      .dirty     (entry_dirty[i]),
      .tag       (entry_tag[i]),
      .lookup_hit(entry_hit[i])
    );
  end

  line_output_select #(
    .NUM_LINES (NUM_LINES),
    .ADDR_WIDTH(ADDR_WIDTH),
    .LINE_WIDTH(LINE_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_select (
    .index      (addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH]),
    .entry_data (entry_data),
    .entry_valid(entry_valid),
    .entry_dirty(entry_dirty),
    .entry_tag  (entry_tag),
    .entry_hit  (entry_hit),
    .enable     (enable),
    .is_load    (is_load),
    .line_data  (line_data),
    .cache_miss (cache_miss),
    .cache_evict(cache_evict),
    .evict_addr (evict_addr)
  );

  // Victim already written back, only the fill is still owed
  always_ff @(posedge clk) begin
    if (rst) begin
      evict_sent <= 1'b0;
    end else if (mem_resp || !cache_miss) begin
      evict_sent <= 1'b0;
    end else if (arbiter_grant && mem_req_write) begin
      evict_sent <= 1'b1;
    end
  end

  always_comb begin
    miss          = cache_miss;
    write_back    = cache_evict && !evict_sent;
    arbiter_req   = write_back || (cache_miss && is_load && !stb_read_valid);
    mem_req_write = write_back;
    mem_req_data  = line_data;
    mem_req_addr  = write_back ? evict_addr
                               : {addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};

    // Word, then byte within it
    word_offset = addr[LINE_OFFSET_WIDTH-1:BYTE_SEL_WIDTH];
    byte_offset = addr[BYTE_SEL_WIDTH-1:0];
    read_word   = line_data[`WORD_WIDTH*word_offset +: `WORD_WIDTH];
    read_byte   = read_word[`BYTE_WIDTH*byte_offset +: `BYTE_WIDTH];
    read_data   = (data_size == brisc_pkg::W) ? read_word
                                              : {{(`XLEN-`BYTE_WIDTH){1'b0}}, read_byte};
  end

  a_addr_known: assert property (
    @(posedge clk) disable iff (rst) enable |-> !$isunknown(addr)
  );

  // A hit must come from a filled or stored line
  a_hit_data_known: assert property (
    @(posedge clk) disable iff (rst) (enable && !miss) |-> !$isunknown(read_data)
  );

endmodule

`default_nettype wire

/* source/line_fill_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module line_fill_engine #(
  parameter int unsigned ADDR_WIDTH = `ADDRESS_WIDTH,
  parameter int unsigned LINE_WIDTH = `CACHE_LINE_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  arbiter_req,
  input  logic [ADDR_WIDTH-1:0] mem_req_addr,
  input  logic [LINE_WIDTH-1:0] mem_req_data,
  input  logic                  mem_req_write,
  output logic                  arbiter_grant,
  output logic                  mem_resp,
  output logic [LINE_WIDTH-1:0] mem_resp_data,
  output logic [ADDR_WIDTH-1:0] mem_resp_addr
);
  localparam int unsigned BYTE_SEL_WIDTH = $clog2(`WORD_WIDTH / `BYTE_WIDTH);
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / `WORD_WIDTH;
  localparam int unsigned WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);
  localparam int unsigned RAM_ADDR_WIDTH = $clog2(`MEM_WORDS);
  localparam int unsigned COUNT_WIDTH = $clog2(`FILL_LATENCY + 1);

  brisc_pkg::fill_state_e   state;
  logic [COUNT_WIDTH-1:0]   count;
  logic [ADDR_WIDTH-1:0]    req_addr;
  logic [LINE_WIDTH-1:0]    req_data;
  logic [`WORD_WIDTH-1:0]   ram [`MEM_WORDS];
  logic                     fill_done;

  // Initial memory image
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      ram[i] = 32'(i) ^ 32'hA5A5_0000;
    end
  end

  assign fill_done     = (state == brisc_pkg::WAIT) && (count == COUNT_WIDTH'(`FILL_LATENCY - 1));
  assign mem_resp      = (state == brisc_pkg::RESPOND);
  assign mem_resp_addr = req_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= brisc_pkg::IDLE;
      arbiter_grant <= 1'b0;
      count         <= '0;
    end else begin
      arbiter_grant <= 1'b0;
      case (state)
        brisc_pkg::IDLE: begin
          if (arbiter_req) begin
            arbiter_grant <= 1'b1;
            count         <= '0;
            state         <= mem_req_write ? brisc_pkg::WRITEBACK : brisc_pkg::WAIT;
          end
        end
        brisc_pkg::WRITEBACK: state <= brisc_pkg::IDLE;
        brisc_pkg::WAIT: begin
          count <= count + 1'b1;
          if (fill_done) state <= brisc_pkg::RESPOND;
        end
        default: state <= brisc_pkg::IDLE;
      endcase
    end
  end

  // Request latch and line read
  always_ff @(posedge clk) begin
    if (state == brisc_pkg::IDLE && arbiter_req) begin
      req_addr <= mem_req_addr;
      req_data <= mem_req_data;
    end
    if (fill_done) begin
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
        mem_resp_data[i*`WORD_WIDTH +: `WORD_WIDTH] <=
          ram[{req_addr[RAM_ADDR_WIDTH+BYTE_SEL_WIDTH-1:BYTE_SEL_WIDTH+WORD_SEL_WIDTH],
               WORD_SEL_WIDTH'(i)}];
      end
    end
  end

  always @(posedge clk) begin
    if (state == brisc_pkg::WRITEBACK) begin
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
        ram[{req_addr[RAM_ADDR_WIDTH+BYTE_SEL_WIDTH-1:BYTE_SEL_WIDTH+WORD_SEL_WIDTH],
             WORD_SEL_WIDTH'(i)}] <= req_data[i*`WORD_WIDTH +: `WORD_WIDTH];
      end
    end
  end

  // Response answers the fill the requester is still waiting for
  a_resp_matches_req: assert property (
    @(posedge clk) disable iff (rst)
      mem_resp |-> (arbiter_req && !mem_req_write && mem_req_addr == mem_resp_addr)
  );

endmodule

`default_nettype wire

/* source/line_output_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module line_output_select #(
  parameter int unsigned NUM_LINES  = `NUM_CACHE_LINES,
  parameter int unsigned ADDR_WIDTH = `ADDRESS_WIDTH,
  parameter int unsigned LINE_WIDTH = `CACHE_LINE_WIDTH,
  parameter int unsigned TAG_WIDTH  = 9
) (
  input  logic [$clog2(NUM_LINES)-1:0] index,
  input  logic [LINE_WIDTH-1:0]        entry_data [NUM_LINES],
  input  logic [NUM_LINES-1:0]         entry_valid,
  input  logic [NUM_LINES-1:0]         entry_dirty,
  input  logic [TAG_WIDTH-1:0]         entry_tag [NUM_LINES],
  input  logic [NUM_LINES-1:0]         entry_hit,
  input  logic                         enable,
  input  logic                         is_load,
  output logic [LINE_WIDTH-1:0]        line_data,
  output logic                         cache_miss,
  output logic                         cache_evict,
  output logic [ADDR_WIDTH-1:0]        evict_addr
);
  localparam int unsigned INDEX_WIDTH = $clog2(NUM_LINES);
  localparam int unsigned OFFSET_WIDTH = ADDR_WIDTH - TAG_WIDTH - INDEX_WIDTH;

  always_comb begin
    line_data  = entry_data[index];
    cache_miss = enable && !entry_hit[index];

    // A load that displaces modified data needs a write-back first
    cache_evict = cache_miss && is_load && entry_valid[index] && entry_dirty[index];

    // Victim address rebuilt from what the line holds
    evict_addr = {entry_tag[index], index, {OFFSET_WIDTH{1'b0}}};
  end

endmodule

`default_nettype wire

/* source/line_write_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module line_write_decode #(
  parameter int unsigned NUM_LINES  = `NUM_CACHE_LINES,
  parameter int unsigned ADDR_WIDTH = `ADDRESS_WIDTH,
  parameter int unsigned LINE_WIDTH = `CACHE_LINE_WIDTH
) (
  input  logic                         mem_resp,
  input  logic [ADDR_WIDTH-1:0]        mem_resp_addr,
  input  logic                         stb_write,
  input  logic [ADDR_WIDTH-1:0]        stb_write_addr,
  input  logic [`XLEN-1:0]             stb_write_data,
  input  brisc_pkg::data_size_e        stb_write_size,
  output logic [NUM_LINES-1:0]         fill_en,
  output logic [NUM_LINES-1:0]         store_en,
  output logic [LINE_WIDTH-1:0]        store_line,
  output logic [LINE_WIDTH/8-1:0]      store_mask
);
  localparam int unsigned BYTES_PER_WORD = `WORD_WIDTH / `BYTE_WIDTH;
  localparam int unsigned BYTES_PER_LINE = LINE_WIDTH / `BYTE_WIDTH;
  localparam int unsigned BYTE_SEL_WIDTH = $clog2(BYTES_PER_WORD);
  localparam int unsigned LINE_OFFSET_WIDTH = $clog2(BYTES_PER_LINE);
  localparam int unsigned INDEX_WIDTH = $clog2(NUM_LINES);

  logic [INDEX_WIDTH-1:0]       fill_index;
  logic [INDEX_WIDTH-1:0]       store_index;
  logic [LINE_OFFSET_WIDTH-1:0] store_offset;
  logic [LINE_OFFSET_WIDTH-1:0] word_base;

  always_comb begin
    fill_index   = mem_resp_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    store_index  = stb_write_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    store_offset = stb_write_addr[LINE_OFFSET_WIDTH-1:0];
    word_base    = {store_offset[LINE_OFFSET_WIDTH-1:BYTE_SEL_WIDTH], {BYTE_SEL_WIDTH{1'b0}}};

    // One-hot line enables
    fill_en  = '0;
    store_en = '0;
    fill_en[fill_index]   = mem_resp;
    store_en[store_index] = stb_write;

    // Data goes to every lane, the mask picks the bytes that land
    store_mask = '0;
    if (stb_write_size == brisc_pkg::W) begin
      store_line = {(LINE_WIDTH / `XLEN){stb_write_data}};
      store_mask[word_base +: BYTES_PER_WORD] = '1;
    end else begin
      store_line = {BYTES_PER_LINE{stb_write_data[`BYTE_WIDTH-1:0]}};
      store_mask[store_offset] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module mem_subsystem (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable,
  input  logic                     is_load,
  input  logic [`ADDRESS_WIDTH-1:0] addr,
  input  brisc_pkg::data_size_e    data_size,
  input  logic                     stb_write,
  input  logic [`ADDRESS_WIDTH-1:0] stb_write_addr,
  input  logic [`XLEN-1:0]         stb_write_data,
  input  brisc_pkg::data_size_e    stb_write_size,
  input  logic                     stb_read_valid,
  output logic                     miss,
  output logic [`XLEN-1:0]         read_data
);
  logic                         arbiter_req;
  logic                         arbiter_grant;
  logic [`ADDRESS_WIDTH-1:0]    mem_req_addr;
  logic [`CACHE_LINE_WIDTH-1:0] mem_req_data;
  logic                         mem_req_write;
  logic                         mem_resp;
  logic [`CACHE_LINE_WIDTH-1:0] mem_resp_data;
  logic [`ADDRESS_WIDTH-1:0]    mem_resp_addr;

  cache_top u_cache (
    .clk(clk), .rst(rst), .enable(enable), .is_load(is_load),
    .addr(addr), .data_size(data_size), .miss(miss), .read_data(read_data),
    .arbiter_grant(arbiter_grant), .arbiter_req(arbiter_req),
    .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data), .mem_req_write(mem_req_write),
    .mem_resp(mem_resp), .mem_resp_data(mem_resp_data), .mem_resp_addr(mem_resp_addr),
    .stb_write_data(stb_write_data), .stb_write_addr(stb_write_addr),
    .stb_read_valid(stb_read_valid), .stb_write(stb_write), .stb_write_size(stb_write_size)
  );

  line_fill_engine u_fill (
    .clk(clk), .rst(rst), .arbiter_req(arbiter_req),
    .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data), .mem_req_write(mem_req_write),
    .arbiter_grant(arbiter_grant), .mem_resp(mem_resp),
    .mem_resp_data(mem_resp_data), .mem_resp_addr(mem_resp_addr)
  );

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
+incdir+test
source/brisc_pkg.sv
source/line_write_decode.sv
source/cache_line_entry.sv
source/line_output_select.sv
source/cache_top.sv
source/line_fill_engine.sv
source/mem_subsystem.sv
test/tb_mem_subsystem.sv

/* test/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  // One pipeline load, held until the miss clears
  task automatic run_load(input logic [15:0] a, input brisc_pkg::data_size_e size,
                          input logic expect_miss);
    @(posedge clk);
    enable    <= 1'b1;
    is_load   <= 1'b1;
    addr      <= a;
    data_size <= size;
    @(negedge clk);
    compare_value("miss", 32'(miss), 32'(expect_miss));
    wait_for_fill(a);
    compare_value("read_data", read_data, expected_read(a, size));
    note_fill(a);
    @(posedge clk);
    enable  <= 1'b0;
    is_load <= 1'b0;
  endtask

  // One store buffer strobe; lands only in a present line
  task automatic store_strobe(input logic [15:0] a, input logic [31:0] data,
                              input brisc_pkg::data_size_e size);
    @(posedge clk);
    stb_write      <= 1'b1;
    stb_write_addr <= a;
    stb_write_data <= data;
    stb_write_size <= size;
    @(posedge clk);
    stb_write <= 1'b0;
    if (line_valid[a[6:4]] && line_tag[a[6:4]] == a[15:7]) begin
      if (size == brisc_pkg::W) begin
        shadow_mem[a[15:2]] = data;
      end else begin
        shadow_mem[a[15:2]][8*a[1:0] +: 8] = data[7:0];
      end
    end
  endtask

  task automatic cold_miss_test();
    int unsigned errors_before;
    errors_before = error_count;
    home_addr = 16'($urandom) & 16'hFFFC;
    run_load(home_addr, brisc_pkg::W, 1'b1);
    run_load(home_addr, brisc_pkg::W, 1'b0);
    finish_test("cold load miss", errors_before);
  endtask

  task automatic byte_load_test();
    int unsigned errors_before;
    errors_before = error_count;
    for (int b = 0; b < 4; b++) begin
      run_load(home_addr | 16'(b), brisc_pkg::B, 1'b0);
    end
    finish_test("byte loads", errors_before);
  endtask

  task automatic store_hit_test();
    int unsigned errors_before;
    logic [15:0] byte_addr;
    logic [15:0] word_addr;
    errors_before = error_count;
    byte_addr = home_addr | 16'($urandom_range(3, 1));
    // Neighbouring word in the same line
    word_addr = home_addr ^ 16'h0004;
    store_strobe(byte_addr, $urandom, brisc_pkg::B);
    store_strobe(word_addr, $urandom, brisc_pkg::W);
    run_load(byte_addr, brisc_pkg::B, 1'b0);
    run_load(home_addr, brisc_pkg::W, 1'b0);
    run_load(word_addr, brisc_pkg::W, 1'b0);
    finish_test("store hit", errors_before);
  endtask

  task automatic store_miss_test();
    int unsigned errors_before;
    logic [15:0] a;
    errors_before = error_count;
    a = absent_addr(home_addr[6:4] + 3'd1);
    @(posedge clk);
    enable    <= 1'b1;
    is_load   <= 1'b0;
    addr      <= a;
    data_size <= brisc_pkg::W;
    @(negedge clk);
    compare_value("miss", 32'(miss), 32'd1);
    store_strobe(a, $urandom, brisc_pkg::W);
    @(negedge clk);
    compare_value("miss", 32'(miss), 32'd1);
    @(posedge clk);
    enable <= 1'b0;
    run_load(a, brisc_pkg::W, 1'b1);
    finish_test("store miss", errors_before);
  endtask

  task automatic dirty_evict_test();
    int unsigned errors_before;
    logic [15:0] x_addr;
    logic [15:0] y_addr;
    logic [31:0] data;
    errors_before = error_count;
    x_addr = home_addr & 16'hFFFC;
    data = $urandom;
    store_strobe(x_addr, data, brisc_pkg::W);
    y_addr = {home_addr[15:7] ^ 9'($urandom_range(511, 1)), home_addr[6:4],
              2'($urandom), 2'b00};
    run_load(y_addr, brisc_pkg::W, 1'b1);
    // Comes back from memory, so the write-back happened
    run_load(x_addr, brisc_pkg::W, 1'b1);
    compare_value("read_data", read_data, data);
    finish_test("dirty eviction", errors_before);
  endtask

  task automatic forward_test();
    int unsigned errors_before;
    logic [15:0] a;
    errors_before = error_count;
    a = absent_addr(home_addr[6:4] + 3'd2);
    @(posedge clk);
    enable         <= 1'b1;
    is_load        <= 1'b1;
    addr           <= a;
    data_size      <= brisc_pkg::W;
    stb_read_valid <= 1'b1;
    repeat (FORWARD_HOLD) begin
      @(negedge clk);
      compare_value("miss", 32'(miss), 32'd1);
    end
    @(posedge clk);
    stb_read_valid <= 1'b0;
    @(negedge clk);
    compare_value("miss", 32'(miss), 32'd1);
    wait_for_fill(a);
    compare_value("read_data", read_data, expected_read(a, brisc_pkg::W));
    note_fill(a);
    @(posedge clk);
    enable  <= 1'b0;
    is_load <= 1'b0;
    finish_test("forwarding", errors_before);
  endtask

`endif

/* test/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "brisc_config.svh"

module tb_mem_subsystem;
  localparam int unsigned TIMEOUT_CYCLES = 3000;
  localparam int unsigned ACCESS_LIMIT   = 40;
  localparam int unsigned RESET_CYCLES   = 4;
  localparam int unsigned FORWARD_HOLD   = 12;

  logic                      clk;
  logic                      rst;
  logic                      enable;
  logic                      is_load;
  logic [`ADDRESS_WIDTH-1:0] addr;
  brisc_pkg::data_size_e     data_size;
  logic                      stb_write;
  logic [`ADDRESS_WIDTH-1:0] stb_write_addr;
  logic [`XLEN-1:0]          stb_write_data;
  brisc_pkg::data_size_e     stb_write_size;
  logic                      stb_read_valid;
  logic                      miss;
  logic [`XLEN-1:0]          read_data;

  // Latest value of every word, and the tag each line should hold
  logic [`WORD_WIDTH-1:0]      shadow_mem [`MEM_WORDS];
  logic [`NUM_CACHE_LINES-1:0] line_valid;
  logic [8:0]                  line_tag [`NUM_CACHE_LINES];

  int unsigned               cycle_count;
  int unsigned               error_count;
  int unsigned               tests_passed;
  int unsigned               tests_failed;
  logic [`ADDRESS_WIDTH-1:0] home_addr;

  mem_subsystem DUT (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .is_load       (is_load),
    .addr          (addr),
    .data_size     (data_size),
    .stb_write     (stb_write),
    .stb_write_addr(stb_write_addr),
    .stb_write_data(stb_write_data),
    .stb_write_size(stb_write_size),
    .stb_read_valid(stb_read_valid),
    .miss          (miss),
    .read_data     (read_data)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [`WORD_WIDTH-1:0] initial_word(input int unsigned word_addr);
    return 32'(word_addr) ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [`XLEN-1:0] expected_read(input logic [15:0] a,
                                                     input brisc_pkg::data_size_e size);
    logic [31:0] word;
    word = shadow_mem[a[15:2]];
    if (size == brisc_pkg::W) begin
      return word;
    end
    return {24'h0, word[8*a[1:0] +: 8]};
  endfunction

  // Address in the given line whose tag is not the one held there
  function automatic logic [15:0] absent_addr(input logic [2:0] idx);
    logic [8:0] tag;
    tag = 9'($urandom);
    if (line_valid[idx] && line_tag[idx] == tag) begin
      tag = tag + 9'd1;
    end
    return {tag, idx, 2'($urandom), 2'b00};
  endfunction

  function automatic void note_fill(input logic [15:0] a);
    line_valid[a[6:4]] = 1'b1;
    line_tag[a[6:4]]   = a[15:7];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_for_fill(input logic [15:0] a);
    int unsigned waited;
    waited = 0;
    while (miss && waited < ACCESS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (miss) begin
      $display("load at address %h still missing after %0d cycles", a, ACCESS_LIMIT);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  `include "tb_tasks.svh"

  initial begin
    void'($urandom(32'hb15b));
    clk            = 1'b0;
    rst            <= 1'b1;
    enable         <= 1'b0;
    is_load        <= 1'b0;
    addr           <= '0;
    data_size      <= brisc_pkg::W;
    stb_write      <= 1'b0;
    stb_write_addr <= '0;
    stb_write_data <= '0;
    stb_write_size <= brisc_pkg::W;
    stb_read_valid <= 1'b0;
    cycle_count    = 0;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    line_valid     = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow_mem[i] = initial_word(i);
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    cold_miss_test();
    byte_load_test();
    store_hit_test();
    store_miss_test();
    dirty_evict_test();
    forward_test();

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
